// ==== hw/dcache_pkg.sv ====
package dcache_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////
  localparam int XLEN          = 32;
  localparam int PLEN          = 32;
  localparam int BLK_BITS      = 64;
  localparam int WAYS          = 2;
  localparam int IDX_BITS      = 4;
  localparam int BLK_OFFS_BITS = 3;
  localparam int DAT_OFFS_BITS = 1;
  localparam int TAG_BITS      = 25;
  localparam int INFLIGHT_BITS = 2;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////
  typedef logic [XLEN-1:0]          xlen_t;
  typedef logic [PLEN-1:0]          padr_t;
  typedef logic [BLK_BITS-1:0]      line_t;
  typedef logic [XLEN/8-1:0]        be_t;
  typedef logic [BLK_BITS/8-1:0]    line_be_t;
  typedef logic [IDX_BITS-1:0]      idx_t;
  typedef logic [TAG_BITS-1:0]      tag_t;
  typedef logic [DAT_OFFS_BITS-1:0] offs_t;
  typedef logic [WAYS-1:0]          ways_t;
  typedef logic [INFLIGHT_BITS-1:0] inflight_t;

  // command to the bus interface unit
  typedef enum logic [1:0] {
    NOP,
    READWAY,
    WRITEWAY
  } biucmd_t;

  // memory side state machine
  typedef enum logic [2:0] {
    ARMED,
    NONCACHEABLE,
    EVICT,
    FILL,
    RECOVER
  } memfsm_t;

  //////////////////////////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic  req;
    logic  wreq;
    logic  cacheable;
    padr_t adr;
    be_t   be;
    xlen_t d;
  } core_req_t;

  typedef struct packed {
    logic  valid;
    logic  store_hit;
    logic  hit_ack;
    logic  cacheable;
    idx_t  idx;
    tag_t  tag;
    offs_t offs;
    be_t   be;
    xlen_t d;
    ways_t ways_hit;
  } dec_req_t;

  typedef struct packed {
    logic  hit;
    ways_t ways_hit;
    line_t line;
    logic  way_dirty;
    ways_t fill_way;
  } cache_rsp_t;

  typedef struct packed {
    xlen_t     q;
    logic      ack;
    logic      stb_ack;
    logic      err;
    padr_t     adro;
    logic      busy;
    logic      cmd_ack;
    logic      nc_ack;
    inflight_t inflight;
  } biu_rsp_t;

  typedef struct packed {
    idx_t     idx;
    offs_t    offs;
    xlen_t    data;
    line_be_t be;
    ways_t    ways_hit;
  } wb_entry_t;

endpackage

// ==== hw/dcache_req_decode.sv ====
module dcache_req_decode (
  input  dcache_pkg::core_req_t  core_req_i,
  input  logic                   flush_i,
  input  dcache_pkg::cache_rsp_t cache_rsp_i,

  output dcache_pkg::dec_req_t   dec_o,
  output dcache_pkg::idx_t       idx_o,
  output dcache_pkg::tag_t       core_tag_o
);

  import dcache_pkg::*;

  logic  valid;
  idx_t  idx;
  tag_t  tag;
  offs_t offs;

  //////////////////////////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////////////////////////
  assign idx  = core_req_i.adr[BLK_OFFS_BITS +: IDX_BITS];
  assign tag  = core_req_i.adr[PLEN-1 -: TAG_BITS];
  // word within the line
  assign offs = core_req_i.adr[BLK_OFFS_BITS-1 -: DAT_OFFS_BITS];

  // towards tag and data memories
  assign idx_o      = idx;
  assign core_tag_o = tag;

  assign valid = core_req_i.req;

  //////////////////////////////////////////////////////////////////////
  // qualified request
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    dec_o.valid     = valid;
    dec_o.cacheable = core_req_i.cacheable;
    // hit acknowledge is suppressed by a pipe flush
    dec_o.hit_ack   = valid & core_req_i.cacheable & cache_rsp_i.hit & ~flush_i;
    dec_o.store_hit = valid & core_req_i.wreq & core_req_i.cacheable & cache_rsp_i.hit;
    dec_o.idx       = idx;
    dec_o.tag       = tag;
    dec_o.offs      = offs;
    dec_o.be        = core_req_i.be;
    dec_o.d         = core_req_i.d;
    dec_o.ways_hit  = cache_rsp_i.ways_hit;
  end

endmodule

// ==== hw/dcache_write_buffer.sv ====
module dcache_write_buffer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  dcache_pkg::dec_req_t  dec_i,
  input  logic                  writebuffer_ack_i,

  output logic                  wb_we_o,
  output dcache_pkg::wb_entry_t wb_o
);

  import dcache_pkg::*;

  line_be_t line_be;

  // byte enables moved to the word's place in the line
  assign line_be = line_be_t'(dec_i.be) << (dec_i.offs * (XLEN/8));

  //////////////////////////////////////////////////////////////////////
  // write strobe
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wb_we_o <= 1'b0;
    end
    else if (flush_i)
    begin
      wb_we_o <= 1'b0;
    end
    else if (dec_i.store_hit)
    begin
      wb_we_o <= 1'b1;
    end
    else if (writebuffer_ack_i)
    begin
      wb_we_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // entry
  //////////////////////////////////////////////////////////////////////
  // a newer store hit simply overwrites the pending one
  always_ff @(posedge clk_i)
  begin
    if (dec_i.store_hit)
    begin
      wb_o.idx      <= dec_i.idx;
      wb_o.offs     <= dec_i.offs;
      wb_o.data     <= dec_i.d;
      wb_o.be       <= line_be;
      wb_o.ways_hit <= dec_i.ways_hit;
    end
  end

endmodule

// ==== hw/dcache_mem_ctrl.sv ====
module dcache_mem_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  dcache_pkg::dec_req_t   dec_i,
  input  dcache_pkg::cache_rsp_t cache_rsp_i,
  input  dcache_pkg::biu_rsp_t   biu_rsp_i,
  input  dcache_pkg::tag_t       evict_tag_i,
  input  dcache_pkg::line_t      evict_line_i,

  output dcache_pkg::memfsm_t    state_o,
  output dcache_pkg::biucmd_t    biucmd_o,
  output logic                   noncacheable_req_o,
  output dcache_pkg::ways_t      fill_way_o,
  output logic                   armed_o,
  output logic                   filling_o,
  output logic                   stall_o,
  output logic                   ack_o,
  output dcache_pkg::padr_t      evictbuffer_adr_o,
  output dcache_pkg::line_t      evictbuffer_line_o
);

  import dcache_pkg::*;

  memfsm_t state, nxt_state;
  biucmd_t nxt_biucmd;
  ways_t   nxt_fill_way;
  logic    adro_match;
  logic    biu_cacheable_ack;
  logic    miss_go, nc_go;

  assign state_o = state;

  // word address of the BIU response against the request
  assign adro_match = biu_rsp_i.adro[PLEN-1:BLK_OFFS_BITS-DAT_OFFS_BITS] ==
                      {dec_i.tag, dec_i.idx, dec_i.offs};

  assign biu_cacheable_ack = (dec_i.valid & biu_rsp_i.ack & adro_match & ~flush_i) |
                             dec_i.hit_ack;

  // leaving ARMED is blocked while the BIU is busy
  assign nc_go   = dec_i.valid & ~dec_i.cacheable & ~flush_i & ~biu_rsp_i.busy;
  assign miss_go = dec_i.valid & dec_i.cacheable & ~cache_rsp_i.hit & ~flush_i &
                   ~biu_rsp_i.busy;

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    nxt_state    = state;
    nxt_biucmd   = biucmd_o;
    nxt_fill_way = fill_way_o;

    case (state)
      ARMED:
        if (nc_go)
        begin
          nxt_state  = NONCACHEABLE;
          nxt_biucmd = NOP;
        end
        else if (miss_go)
        begin
          // refill goes into the way selected by the tag memory
          nxt_fill_way = cache_rsp_i.fill_way;
          nxt_state    = cache_rsp_i.way_dirty ? EVICT : FILL;
          nxt_biucmd   = READWAY;
        end
      NONCACHEABLE:
        if (flush_i ||
            (!dec_i.valid && biu_rsp_i.inflight == inflight_t'(1) && biu_rsp_i.ack) ||
            (dec_i.valid && dec_i.cacheable && biu_rsp_i.ack))
        begin
          nxt_state  = ARMED;
          nxt_biucmd = NOP;
        end
      EVICT:
        if (biu_rsp_i.cmd_ack || biu_rsp_i.err)
        begin
          // new line is in, now write back the old one
          nxt_state  = RECOVER;
          nxt_biucmd = WRITEWAY;
        end
      FILL:
        if (biu_rsp_i.cmd_ack || biu_rsp_i.err)
        begin
          nxt_state  = RECOVER;
          nxt_biucmd = NOP;
        end
      default:
      begin
        nxt_state  = ARMED;
        nxt_biucmd = NOP;
      end
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state      <= ARMED;
      biucmd_o   <= NOP;
      fill_way_o <= '0;
      armed_o    <= 1'b1;
      filling_o  <= 1'b0;
    end
    else
    begin
      state      <= nxt_state;
      biucmd_o   <= nxt_biucmd;
      fill_way_o <= nxt_fill_way;
      armed_o    <= nxt_state == ARMED;
      filling_o  <= (nxt_state == EVICT) || (nxt_state == FILL);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // core side
  //////////////////////////////////////////////////////////////////////
  assign noncacheable_req_o = (state == ARMED) & dec_i.valid & ~dec_i.cacheable & ~flush_i;

  always_comb
  begin
    case (state)
      ARMED:
        stall_o = (dec_i.valid & ~dec_i.cacheable & (~biu_rsp_i.stb_ack | biu_rsp_i.busy)) |
                  (dec_i.valid & dec_i.cacheable & ~cache_rsp_i.hit);
      // idle core waits for outstanding transfers to drain
      NONCACHEABLE:
        stall_o = ~dec_i.valid ? |biu_rsp_i.inflight : dec_i.cacheable | biu_rsp_i.ack;
      EVICT, FILL:
        stall_o = ~(biu_cacheable_ack | (dec_i.valid & cache_rsp_i.hit));
      RECOVER:
        stall_o = ~(dec_i.valid & cache_rsp_i.hit);
      default:
        stall_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_o <= 1'b0;
    end
    else
    begin
      case (state)
        ARMED, RECOVER: ack_o <= dec_i.hit_ack;
        NONCACHEABLE:   ack_o <= biu_rsp_i.nc_ack;
        EVICT, FILL:    ack_o <= biu_cacheable_ack;
        default:        ack_o <= 1'b0;
      endcase
    end
  end

  // victim line is captured while the tag memory still shows it
  always_ff @(posedge clk_i)
  begin
    if (state == ARMED)
    begin
      evictbuffer_adr_o  <= {evict_tag_i, dec_i.idx, {BLK_OFFS_BITS{1'b0}}};
      evictbuffer_line_o <= evict_line_i;
    end
  end

endmodule

// ==== hw/dcache_read_merge.sv ====
module dcache_read_merge (
  input  logic                   clk_i,
  input  dcache_pkg::dec_req_t   dec_i,
  input  dcache_pkg::memfsm_t    state_i,
  input  dcache_pkg::cache_rsp_t cache_rsp_i,
  input  logic                   wb_we_i,
  input  dcache_pkg::wb_entry_t  wb_i,
  input  dcache_pkg::biu_rsp_t   biu_rsp_i,

  output dcache_pkg::xlen_t      q_o,
  output logic                   err_o
);

  import dcache_pkg::*;

  logic  bypass;
  line_t merged_line;
  xlen_t cache_q;

  // pending store targets the set being read
  assign bypass = wb_we_i & (dec_i.idx == wb_i.idx);

  //////////////////////////////////////////////////////////////////////
  // store bypass
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    merged_line = cache_rsp_i.line;
    for (int i = 0; i < BLK_BITS/8; i++)
    begin
      // buffered data is replicated across every word of the line
      if (bypass && wb_i.be[i])
      begin
        merged_line[i*8 +: 8] = wb_i.data[(i % (XLEN/8))*8 +: 8];
      end
    end
  end

  assign cache_q = merged_line[dec_i.offs*XLEN +: XLEN];

  //////////////////////////////////////////////////////////////////////
  // registered read data
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    case (state_i)
      // during a refill only a hit comes from the cache
      FILL, EVICT: q_o <= cache_rsp_i.hit ? cache_q : biu_rsp_i.q;
      default:     q_o <= dec_i.cacheable ? cache_q : biu_rsp_i.q;
    endcase
  end

  // bus access error towards the core
  always_ff @(posedge clk_i)
  begin
    err_o <= biu_rsp_i.err;
  end

endmodule

// ==== hw/dcache_hit.sv ====
module dcache_hit (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // core
  input  dcache_pkg::core_req_t  core_req_i,
  input  logic                   flush_i,
  output logic                   stall_o,
  output logic                   ack_o,
  output dcache_pkg::xlen_t      q_o,
  output logic                   err_o,

  // cache memories
  input  dcache_pkg::cache_rsp_t cache_rsp_i,
  output dcache_pkg::idx_t       idx_o,
  output dcache_pkg::tag_t       core_tag_o,

  // write buffer
  output logic                   writebuffer_we_o,
  output dcache_pkg::wb_entry_t  writebuffer_o,
  input  logic                   writebuffer_ack_i,

  // evict buffer
  input  dcache_pkg::tag_t       evict_tag_i,
  input  dcache_pkg::line_t      evict_line_i,
  output dcache_pkg::padr_t      evictbuffer_adr_o,
  output dcache_pkg::line_t      evictbuffer_line_o,

  // bus interface unit
  input  dcache_pkg::biu_rsp_t   biu_rsp_i,
  output dcache_pkg::biucmd_t    biucmd_o,
  output logic                   noncacheable_req_o,
  output dcache_pkg::ways_t      fill_way_o,

  // status
  output logic                   armed_o,
  output logic                   filling_o
);

  import dcache_pkg::*;

  dec_req_t dec;
  memfsm_t  state;

  dcache_req_decode u_req_decode (
    .core_req_i  (core_req_i),
    .flush_i     (flush_i),
    .cache_rsp_i (cache_rsp_i),
    .dec_o       (dec),
    .idx_o       (idx_o),
    .core_tag_o  (core_tag_o)
  );

  dcache_write_buffer u_write_buffer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .dec_i             (dec),
    .writebuffer_ack_i (writebuffer_ack_i),
    .wb_we_o           (writebuffer_we_o),
    .wb_o              (writebuffer_o)
  );

  dcache_mem_ctrl u_mem_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .dec_i              (dec),
    .cache_rsp_i        (cache_rsp_i),
    .biu_rsp_i          (biu_rsp_i),
    .evict_tag_i        (evict_tag_i),
    .evict_line_i       (evict_line_i),
    .state_o            (state),
    .biucmd_o           (biucmd_o),
    .noncacheable_req_o (noncacheable_req_o),
    .fill_way_o         (fill_way_o),
    .armed_o            (armed_o),
    .filling_o          (filling_o),
    .stall_o            (stall_o),
    .ack_o              (ack_o),
    .evictbuffer_adr_o  (evictbuffer_adr_o),
    .evictbuffer_line_o (evictbuffer_line_o)
  );

  dcache_read_merge u_read_merge (
    .clk_i       (clk_i),
    .dec_i       (dec),
    .state_i     (state),
    .cache_rsp_i (cache_rsp_i),
    .wb_we_i     (writebuffer_we_o),
    .wb_i        (writebuffer_o),
    .biu_rsp_i   (biu_rsp_i),
    .q_o         (q_o),
    .err_o       (err_o)
  );

endmodule

// ==== test/dcache_hit_tests.svh ====
`ifndef DCACHE_HIT_TESTS_SVH
`define DCACHE_HIT_TESTS_SVH

  task automatic read_hit();
    padr_t adr;
    line_t line;
    adr  = next_rand();
    line = {next_rand(), next_rand()};
    @(posedge clk);
    issue_req(1'b0, 1'b1, adr, 4'hf, '0);
    set_cache_rsp(1'b1, 2'b01, line, 1'b0, 2'b01);
    @(negedge clk);
    check_bit("stall_o", stall, 1'b0);
    check_word("idx_o", xlen_t'(idx), xlen_t'(adr[6:3]));
    check_word("core_tag_o", xlen_t'(core_tag), xlen_t'(adr[31:7]));
    @(posedge clk);
    release_core();
    @(negedge clk);
    check_bit("ack_o", ack, 1'b1);
    // address bit 2 picks the word
    check_word("q_o", q, adr[2] ? line[63:32] : line[31:0]);
  endtask

  task automatic ack_store();
    @(posedge clk);
    wb_ack <= 1'b1;
    @(posedge clk);
    wb_ack <= 1'b0;
    expect_wb_idle();
  endtask

  task automatic store_hit();
    padr_t adr;
    be_t   be;
    xlen_t d;
    adr    = next_rand();
    adr[2] = 1'b1;
    be     = be_t'(next_rand()) | 4'b0001;
    d      = next_rand();
    @(posedge clk);
    issue_req(1'b1, 1'b1, adr, be, d);
    set_cache_rsp(1'b1, 2'b10, {next_rand(), next_rand()}, 1'b0, 2'b10);
    @(posedge clk);
    release_core();
    @(negedge clk);
    check_bit("writebuffer_we_o", wb_we, 1'b1);
    check_word("writebuffer_o.idx", xlen_t'(wb_entry.idx), xlen_t'(adr[6:3]));
    check_bit("writebuffer_o.offs", wb_entry.offs, 1'b1);
    check_word("writebuffer_o.data", wb_entry.data, d);
    // upper word of the line
    check_word("writebuffer_o.be", xlen_t'(wb_entry.be), xlen_t'({be, 4'b0000}));
    check_word("writebuffer_o.ways_hit", xlen_t'(wb_entry.ways_hit), xlen_t'(2'b10));
    repeat (2) @(negedge clk);
    check_bit("writebuffer_we_o", wb_we, 1'b1);
    ack_store();
  endtask

  task automatic store_bypass();
    padr_t adr;
    be_t   be;
    xlen_t d;
    line_t line;
    xlen_t word;
    int    k;
    adr  = next_rand();
    be   = be_t'(next_rand()) | 4'b0100;
    d    = next_rand();
    line = {next_rand(), next_rand()};
    @(posedge clk);
    issue_req(1'b1, 1'b1, adr, be, d);
    set_cache_rsp(1'b1, 2'b01, {next_rand(), next_rand()}, 1'b0, 2'b01);
    // read the same word while the store is still pending
    @(posedge clk);
    issue_req(1'b0, 1'b1, adr, 4'hf, '0);
    set_cache_rsp(1'b1, 2'b01, line, 1'b0, 2'b01);
    @(posedge clk);
    release_core();
    @(negedge clk);
    word = adr[2] ? line[63:32] : line[31:0];
    for (k = 0; k < 4; k++)
    begin
      if (be[k])
      begin
        word[k*8 +: 8] = d[k*8 +: 8];
      end
    end
    check_word("q_o", q, word);
    ack_store();
  endtask

  task automatic pulse_cmd_ack();
    @(posedge clk);
    biu_rsp.cmd_ack <= 1'b1;
    @(posedge clk);
    biu_rsp.cmd_ack <= 1'b0;
  endtask

  // BIU returns the requested word after a few idle cycles
  task automatic return_biu_word(input padr_t adr, input xlen_t bq);
    int gap;
    gap = int'(next_rand() % 3) + 1;
    repeat (gap) @(posedge clk);
    @(posedge clk);
    biu_rsp.ack  <= 1'b1;
    biu_rsp.adro <= adr;
    biu_rsp.q    <= bq;
    wait_stall_low();
    @(posedge clk);
    biu_rsp.ack <= 1'b0;
    release_core();
    @(negedge clk);
    check_bit("ack_o", ack, 1'b1);
    check_word("q_o", q, bq);
  endtask

  task automatic clean_miss();
    padr_t adr;
    ways_t way;
    adr = next_rand();
    way = ((next_rand() & 32'd1) != 0) ? 2'b10 : 2'b01;
    @(posedge clk);
    issue_req(1'b0, 1'b1, adr, 4'hf, '0);
    set_cache_rsp(1'b0, 2'b00, {next_rand(), next_rand()}, 1'b0, way);
    @(negedge clk);
    check_bit("stall_o", stall, 1'b1);
    @(negedge clk);
    check_cmd("biucmd_o", biucmd, READWAY);
    check_word("fill_way_o", xlen_t'(fill_way), xlen_t'(way));
    check_bit("filling_o", filling, 1'b1);
    check_bit("stall_o", stall, 1'b1);
    return_biu_word(adr, next_rand());
    pulse_cmd_ack();
    expect_armed();
    check_cmd("biucmd_o", biucmd, NOP);
    check_bit("filling_o", filling, 1'b0);
  endtask

  task automatic dirty_miss();
    padr_t adr;
    tag_t  etag;
    line_t eline;
    adr   = next_rand();
    etag  = tag_t'(next_rand());
    eline = {next_rand(), next_rand()};
    @(posedge clk);
    issue_req(1'b0, 1'b1, adr, 4'hf, '0);
    set_cache_rsp(1'b0, 2'b00, {next_rand(), next_rand()}, 1'b1, 2'b10);
    evict_tag  <= etag;
    evict_line <= eline;
    @(posedge clk);
    // victim inputs move on, the captured copy must not
    evict_tag  <= ~etag;
    evict_line <= ~eline;
    @(negedge clk);
    check_adr("evictbuffer_adr_o", evict_adr, {etag, adr[6:3], 3'b000});
    check_line("evictbuffer_line_o", evict_line_q, eline);
    check_cmd("biucmd_o", biucmd, READWAY);
    return_biu_word(adr, next_rand());
    // still the victim seen on entry to the miss
    check_adr("evictbuffer_adr_o", evict_adr, {etag, adr[6:3], 3'b000});
    check_line("evictbuffer_line_o", evict_line_q, eline);
    pulse_cmd_ack();
    @(negedge clk);
    check_cmd("biucmd_o", biucmd, WRITEWAY);
    expect_armed();
    @(posedge clk);
    biu_rsp.err <= 1'b1;
    @(posedge clk);
    biu_rsp.err <= 1'b0;
    @(negedge clk);
    check_bit("err_o", err, 1'b1);
    @(negedge clk);
    check_bit("err_o", err, 1'b0);
  endtask

  task automatic noncacheable_access();
    padr_t adr;
    xlen_t bq;
    adr = next_rand();
    bq  = next_rand();
    @(posedge clk);
    issue_req(1'b0, 1'b0, adr, 4'hf, '0);
    set_cache_rsp(1'b0, 2'b00, '0, 1'b0, 2'b01);
    @(negedge clk);
    check_bit("noncacheable_req_o", nc_req, 1'b1);
    check_bit("stall_o", stall, 1'b1);
    @(posedge clk);
    biu_rsp.inflight <= inflight_t'(1);
    wait_stall_low();
    @(posedge clk);
    release_core();
    @(negedge clk);
    // idle core waits for the transfer in flight
    check_bit("stall_o", stall, 1'b1);
    @(posedge clk);
    biu_rsp.ack    <= 1'b1;
    biu_rsp.nc_ack <= 1'b1;
    biu_rsp.adro   <= adr;
    biu_rsp.q      <= bq;
    @(posedge clk);
    biu_rsp.ack      <= 1'b0;
    biu_rsp.nc_ack   <= 1'b0;
    biu_rsp.inflight <= '0;
    @(negedge clk);
    check_bit("ack_o", ack, 1'b1);
    check_word("q_o", q, bq);
    expect_armed();
  endtask

  task automatic run_tests();
    read_hit();
    store_hit();
    store_bypass();
    clean_miss();
    dirty_miss();
    noncacheable_access();
  endtask

`endif

// ==== test/dcache_hit_tb.sv ====
module dcache_hit_tb;

  import dcache_pkg::*;

  localparam int TIMEOUT = 50;

  logic       clk;
  logic       rst_n;
  core_req_t  core_req;
  logic       flush;
  cache_rsp_t cache_rsp;
  logic       wb_ack;
  tag_t       evict_tag;
  line_t      evict_line;
  biu_rsp_t   biu_rsp;

  logic       stall;
  logic       ack;
  logic       err;
  logic       wb_we;
  logic       nc_req;
  logic       armed;
  logic       filling;
  xlen_t      q;
  idx_t       idx;
  tag_t       core_tag;
  wb_entry_t  wb_entry;
  padr_t      evict_adr;
  line_t      evict_line_q;
  biucmd_t    biucmd;
  ways_t      fill_way;

  logic [31:0] rng_state;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  dcache_hit UUT (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .core_req_i         (core_req),
    .flush_i            (flush),
    .stall_o            (stall),
    .ack_o              (ack),
    .q_o                (q),
    .err_o              (err),
    .cache_rsp_i        (cache_rsp),
    .idx_o              (idx),
    .core_tag_o         (core_tag),
    .writebuffer_we_o   (wb_we),
    .writebuffer_o      (wb_entry),
    .writebuffer_ack_i  (wb_ack),
    .evict_tag_i        (evict_tag),
    .evict_line_i       (evict_line),
    .evictbuffer_adr_o  (evict_adr),
    .evictbuffer_line_o (evict_line_q),
    .biu_rsp_i          (biu_rsp),
    .biucmd_o           (biucmd),
    .noncacheable_req_o (nc_req),
    .fill_way_o         (fill_way),
    .armed_o            (armed),
    .filling_o          (filling)
  );

  //////////////////////////////////////////////////////////////////////
  // random numbers and compare tasks
  //////////////////////////////////////////////////////////////////////
  // 32-bit xorshift
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic end_with_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp)
    begin
      end_with_failure($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp)
    begin
      end_with_failure($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_adr(input string name, input padr_t got, input padr_t exp);
    if (got !== exp)
    begin
      end_with_failure($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_cmd(input string name, input biucmd_t got, input biucmd_t exp);
    if (got !== exp)
    begin
      end_with_failure($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      end_with_failure($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers, called right after a rising edge
  //////////////////////////////////////////////////////////////////////
  task automatic issue_req(input logic wreq, input logic cacheable, input padr_t adr,
                           input be_t be, input xlen_t d);
    core_req.req       <= 1'b1;
    core_req.wreq      <= wreq;
    core_req.cacheable <= cacheable;
    core_req.adr       <= adr;
    core_req.be        <= be;
    core_req.d         <= d;
  endtask

  // cacheable stays as it was
  task automatic release_core();
    core_req.req  <= 1'b0;
    core_req.wreq <= 1'b0;
  endtask

  task automatic set_cache_rsp(input logic hit, input ways_t ways_hit, input line_t line,
                               input logic dirty, input ways_t fill);
    cache_rsp.hit       <= hit;
    cache_rsp.ways_hit  <= ways_hit;
    cache_rsp.line      <= line;
    cache_rsp.way_dirty <= dirty;
    cache_rsp.fill_way  <= fill;
  endtask

  task automatic wait_stall_low();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (stall !== 1'b0 && n < TIMEOUT);
    if (stall !== 1'b0)
    begin
      end_with_failure("stall_o stayed high past the timeout");
    end
  endtask

  task automatic expect_armed();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (armed !== 1'b1 && n < TIMEOUT);
    if (armed !== 1'b1)
    begin
      end_with_failure("armed_o did not return within the timeout");
    end
  endtask

  task automatic expect_wb_idle();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (wb_we !== 1'b0 && n < TIMEOUT);
    if (wb_we !== 1'b0)
    begin
      end_with_failure("writebuffer_we_o did not drop after the acknowledge");
    end
  endtask

  `include "dcache_hit_tests.svh"

  initial
  begin
    rng_state = 32'd6;
    rst_n      <= 1'b0;
    core_req   <= '0;
    flush      <= 1'b0;
    cache_rsp  <= '0;
    wb_ack     <= 1'b0;
    evict_tag  <= '0;
    evict_line <= '0;
    biu_rsp    <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    // state right after reset
    check_bit("ack_o", ack, 1'b0);
    check_bit("writebuffer_we_o", wb_we, 1'b0);
    check_cmd("biucmd_o", biucmd, NOP);
    check_bit("filling_o", filling, 1'b0);
    check_bit("armed_o", armed, 1'b1);
    run_tests();
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+test
hw/dcache_pkg.sv
hw/dcache_req_decode.sv
hw/dcache_write_buffer.sv
hw/dcache_mem_ctrl.sv
hw/dcache_read_merge.sv
hw/dcache_hit.sv
test/dcache_hit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dcache hit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module dcache_hit_tb -o dcache_hit_sim \
  || exit 1
out=$(./obj_dir/dcache_hit_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF '>>> PASS' && exit 0 || exit 1
